/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_data_port
FILELIST  = src.f
OBJ_DIR   = obj_dir
SIMFLAGS  = +verilator+error+limit+1000
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* data_port_top.sv */
`timescale 1ns/1ps

module data_port_top import lsu_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  logic [XLEN-1:0]    adr,
    input  logic [XLEN-1:0]    dat_w,
    input  logic [2:0]         size,
    output logic [XLEN-1:0]    dat_r,
    output logic               ack,
    input  logic [BTN_W-1:0]   buttons,
    input  logic [SW_W-1:0]    switches,
    output logic [LED_W-1:0]   leds,
    output logic [FCW_W-1:0]   car_fcw,
    output logic [FCW_W-1:0]   mod_fcw,
    output logic [SHIFT_W-1:0] mod_shift,
    output logic               note_en,
    output logic               tx_en
);

    logic              accept;
    logic              ram_sel;
    logic              io_sel;
    logic [XLEN-1:0]   ram_word;
    logic [XLEN-1:0]   io_word;
    logic [STRB_W-1:0] strb;
    logic [STRB_W-1:0] ram_strb;
    logic [XLEN-1:0]   lane_data;

    // Loads must not write any lane
    assign ram_strb = we ? strb : '0;

    wb_access_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .cyc      (cyc),
        .stb      (stb),
        .adr      (adr),
        .size     (size),
        .accept   (accept),
        .ram_sel  (ram_sel),
        .io_sel   (io_sel),
        .ram_word (ram_word),
        .io_word  (io_word),
        .dat_r    (dat_r),
        .ack      (ack)
    );

    store_lane_align u_align (
        .size      (size),
        .offset    (adr[1:0]),
        .wdata     (dat_w),
        .strb      (strb),
        .lane_data (lane_data)
    );

    data_ram #(.DEPTH_W(RAM_ADDR_W)) u_ram (
        .clk  (clk),
        .en   (accept & ram_sel),
        .strb (ram_strb),
        .addr (adr[RAM_ADDR_W+1:2]),
        .din  (lane_data),
        .dout (ram_word)
    );

    io_regs u_io (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .io_sel    (io_sel),
        .we        (we),
        .size      (size),
        .adr       (adr),
        .dat_w     (dat_w),
        .buttons   (buttons),
        .switches  (switches),
        .io_word   (io_word),
        .leds      (leds),
        .car_fcw   (car_fcw),
        .mod_fcw   (mod_fcw),
        .mod_shift (mod_shift),
        .note_en   (note_en),
        .tx_en     (tx_en)
    );

endmodule

/* data_ram.sv */
`timescale 1ns/1ps

module data_ram import lsu_pkg::*; #(
    parameter int DEPTH_W = RAM_ADDR_W
) (
    input  logic               clk,
    input  logic               en,
    input  logic [STRB_W-1:0]  strb,
    input  logic [DEPTH_W-1:0] addr,
    input  logic [XLEN-1:0]    din,
    output logic [XLEN-1:0]    dout
);

    logic [XLEN-1:0] mem [0:(2**DEPTH_W)-1];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (strb[i]) begin
                    mem[addr][8*i +: 8] <= din[8*i +: 8];
                end
            end
            dout <= mem[addr];  // Old word on a write, read-first
        end
    end

endmodule

/* io_regs.sv */
`timescale 1ns/1ps

module io_regs import lsu_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               accept,
    input  logic               io_sel,
    input  logic               we,
    input  logic [2:0]         size,
    input  logic [XLEN-1:0]    adr,
    input  logic [XLEN-1:0]    dat_w,
    input  logic [BTN_W-1:0]   buttons,
    input  logic [SW_W-1:0]    switches,
    output logic [XLEN-1:0]    io_word,
    output logic [LED_W-1:0]   leds,
    output logic [FCW_W-1:0]   car_fcw,
    output logic [FCW_W-1:0]   mod_fcw,
    output logic [SHIFT_W-1:0] mod_shift,
    output logic               note_en,
    output logic               tx_en
);

    logic            io_wr;
    logic            io_rd;
    logic            cnt_clr;
    logic [XLEN-1:0] cycle_cnt;

    assign io_wr = accept & io_sel & we;
    assign io_rd = accept & io_sel & ~we;

    // Only a full word store clears the counter
    assign cnt_clr = io_wr && (size == F3_SW) && (adr == ADDR_CYCLE_CLR);

    always_ff @(posedge clk) begin
        if (rst || cnt_clr) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // Output registers take the unshifted store data
    always_ff @(posedge clk) begin
        if (rst) begin
            leds      <= '0;
            car_fcw   <= '0;
            mod_fcw   <= '0;
            mod_shift <= '0;
            note_en   <= 1'b0;
            tx_en     <= 1'b0;
        end else if (io_wr) begin
            case (adr)
                ADDR_LEDS:      leds      <= dat_w[LED_W-1:0];
                ADDR_CAR_FCW:   car_fcw   <= dat_w[FCW_W-1:0];
                ADDR_MOD_FCW:   mod_fcw   <= dat_w[FCW_W-1:0];
                ADDR_MOD_SHIFT: mod_shift <= dat_w[SHIFT_W-1:0];
                ADDR_NOTE_EN:   note_en   <= dat_w[0];
                ADDR_TX_EN:     tx_en     <= dat_w[0];
                default:        ;
            endcase
        end
    end

    // Read word captured on the acceptance edge
    always_ff @(posedge clk) begin
        if (io_rd) begin
            case (adr)
                ADDR_CYCLE:    io_word <= cycle_cnt;
                ADDR_BUTTONS:  io_word <= {{(XLEN-BTN_W){1'b0}}, buttons};
                ADDR_SWITCHES: io_word <= {{(XLEN-SW_W){1'b0}}, switches};
                default:       io_word <= '0;   // Unmapped
            endcase
        end
    end

endmodule

/* load_extend.sv */
`timescale 1ns/1ps

module load_extend import lsu_pkg::*; (
    input  logic [2:0]      size,
    input  logic [1:0]      offset,
    input  logic [XLEN-1:0] word,
    output logic [XLEN-1:0] value
);

    logic [XLEN-1:0] shifted;
    logic [7:0]      byte_val;
    logic [15:0]     half_val;

    // Bring the addressed lane down to bit 0
    assign shifted  = word >> {offset, 3'b000};
    assign byte_val = shifted[7:0];
    assign half_val = shifted[15:0];

    always_comb begin
        case (size)
            F3_LB:   value = {{(XLEN-8){byte_val[7]}}, byte_val};
            F3_LBU:  value = {{(XLEN-8){1'b0}}, byte_val};
            F3_LH:   value = {{(XLEN-16){half_val[15]}}, half_val};
            F3_LHU:  value = {{(XLEN-16){1'b0}}, half_val};
            F3_LW:   value = word;
            default: value = word;
        endcase
    end

endmodule

/* lsu_pkg.sv */
package lsu_pkg;

    // Bus and lane widths
    localparam int XLEN       = 32;
    localparam int STRB_W     = XLEN / 8;
    localparam int RAM_ADDR_W = 14;           // Word address, 64 KiB of data RAM

    // Board I/O widths
    localparam int FCW_W   = 24;
    localparam int LED_W   = 6;
    localparam int SHIFT_W = 5;
    localparam int BTN_W   = 3;
    localparam int SW_W    = 2;

    // Load size codes, RISC-V funct3
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // Store size codes
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // Counter and board inputs
    localparam logic [XLEN-1:0] ADDR_CYCLE     = 32'h8000_0010;
    localparam logic [XLEN-1:0] ADDR_CYCLE_CLR = 32'h8000_0018;
    localparam logic [XLEN-1:0] ADDR_BUTTONS   = 32'h8000_0024;
    localparam logic [XLEN-1:0] ADDR_SWITCHES  = 32'h8000_0028;

    // Output registers
    localparam logic [XLEN-1:0] ADDR_LEDS      = 32'h8000_0030;
    localparam logic [XLEN-1:0] ADDR_CAR_FCW   = 32'h8000_0100;
    localparam logic [XLEN-1:0] ADDR_MOD_FCW   = 32'h8000_0200;
    localparam logic [XLEN-1:0] ADDR_MOD_SHIFT = 32'h8000_0204;
    localparam logic [XLEN-1:0] ADDR_NOTE_EN   = 32'h8000_0208;
    localparam logic [XLEN-1:0] ADDR_TX_EN     = 32'h8000_0210;

endpackage

/* src.f */
lsu_pkg.sv
load_extend.sv
store_lane_align.sv
data_ram.sv
io_regs.sv
wb_access_ctrl.sv
data_port_top.sv
tb_data_port_assert.sv
tb_checker.sv
tb_data_port.sv

/* store_lane_align.sv */
`timescale 1ns/1ps

module store_lane_align import lsu_pkg::*; (
    input  logic [2:0]        size,
    input  logic [1:0]        offset,
    input  logic [XLEN-1:0]   wdata,
    output logic [STRB_W-1:0] strb,
    output logic [XLEN-1:0]   lane_data
);

    logic [XLEN-1:0] shifted;

    // Move the low bytes up to the addressed lane
    assign shifted = wdata << {offset, 3'b000};

    always_comb begin
        strb      = '0;
        lane_data = shifted;
        case (size)
            F3_SB: begin
                strb = STRB_W'(1) << offset;
            end
            F3_SH: begin
                case (offset)
                    2'd0:    strb = 4'b0011;
                    2'd1:    strb = 4'b0110;
                    2'd2:    strb = 4'b1100;
                    default: strb = 4'b0000;    // Straddles the word, dropped
                endcase
            end
            F3_SW: begin
                strb      = '1;
                lane_data = wdata;              // Word stores are never shifted
            end
            default: begin
                strb = '0;
            end
        endcase
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import lsu_pkg::*; (
    input  logic               clk, rst, cyc, stb, we, ack,
    input  logic [2:0]         size,
    input  logic [XLEN-1:0]    adr, dat_w, dat_r,
    input  logic [BTN_W-1:0]   buttons,
    input  logic [SW_W-1:0]    switches,
    input  logic [LED_W-1:0]   leds,
    input  logic [FCW_W-1:0]   car_fcw, mod_fcw,
    input  logic [SHIFT_W-1:0] mod_shift,
    input  logic               note_en, tx_en,
    output int                 mismatches, failures, acks
);

    logic [7:0]      ram_model [int unsigned];  // Keyed by byte offset in the RAM
    logic [XLEN-1:0] port_m [6];    // leds, car_fcw, mod_fcw, mod_shift, note_en, tx_en
    logic            due;           // Accepted on the last edge
    logic            r_we, r_cycle, cnt_seen, cnt_cleared;
    logic [XLEN-1:0] r_exp, cnt_last;
    int              mismatch_cnt = 0;
    int              fail_cnt = 0;
    int              ack_cnt = 0;

    assign mismatches = mismatch_cnt;
    assign failures   = fail_cnt;
    assign acks       = ack_cnt;

    function automatic int unsigned ram_key(input logic [XLEN-1:0] a);
        return 32'(a[RAM_ADDR_W+1:0]);
    endfunction

    function automatic logic [7:0] model_byte(input logic [XLEN-1:0] a);
        return ram_model.exists(ram_key(a)) ? ram_model[ram_key(a)] : 8'h00;
    endfunction

    function automatic void model_store(input logic [2:0] sz, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] d);
        if (sz == F3_SB) begin
            ram_model[ram_key(a)] = d[7:0];
        end else if (sz == F3_SH && a[1:0] != 2'd3) begin
            ram_model[ram_key(a)]     = d[7:0];
            ram_model[ram_key(a + 1)] = d[15:8];
        end else if (sz == F3_SW) begin
            for (int i = 0; i < 4; i++) begin
                ram_model[ram_key({a[XLEN-1:2], 2'b00} + 32'(i))] = d[8*i +: 8];
            end
        end
    endfunction

    function automatic logic [XLEN-1:0] model_load(input logic [2:0] sz, input logic [XLEN-1:0] a);
        logic [7:0]      b0, b1;
        logic [XLEN-1:0] base;
        b0   = model_byte(a);
        b1   = model_byte(a + 1);
        base = {a[XLEN-1:2], 2'b00};
        case (sz)
            F3_LB:   return {{24{b0[7]}}, b0};
            F3_LBU:  return {24'h0, b0};
            F3_LH:   return {{16{b1[7]}}, b1, b0};
            F3_LHU:  return {16'h0, b1, b0};
            default: return {model_byte(base + 3), model_byte(base + 2),
                             model_byte(base + 1), model_byte(base)};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Counter must grow between reads and drop after a clear
    task automatic check_counter(input logic [XLEN-1:0] got);
        if (cnt_seen && (cnt_cleared ? !(got < cnt_last) : !(got > cnt_last))) begin
            mismatch_cnt++;
            $display("mismatch at %0t: dat_r got %0d, expected %s %0d", $time, got,
                     cnt_cleared ? "below" : "above", cnt_last);
        end
        cnt_last    = got;
        cnt_seen    = 1'b1;
        cnt_cleared = 1'b0;
    endtask

    task automatic take_request();
        r_we    = we;
        r_cycle = (adr == ADDR_CYCLE);
        r_exp   = '0;
        if (adr[31:30] == 2'b00 && adr[28]) begin
            if (we) model_store(size, adr, dat_w);
            else r_exp = model_load(size, adr);
        end else if (we) begin
            case (adr)
                ADDR_LEDS:      port_m[0] = XLEN'(dat_w[LED_W-1:0]);
                ADDR_CAR_FCW:   port_m[1] = XLEN'(dat_w[FCW_W-1:0]);
                ADDR_MOD_FCW:   port_m[2] = XLEN'(dat_w[FCW_W-1:0]);
                ADDR_MOD_SHIFT: port_m[3] = XLEN'(dat_w[SHIFT_W-1:0]);
                ADDR_NOTE_EN:   port_m[4] = XLEN'(dat_w[0]);
                ADDR_TX_EN:     port_m[5] = XLEN'(dat_w[0]);
                default:        ;
            endcase
            if (size == F3_SW && adr == ADDR_CYCLE_CLR) cnt_cleared = 1'b1;
        end else if (adr == ADDR_BUTTONS) begin
            r_exp = XLEN'(buttons);
        end else if (adr == ADDR_SWITCHES) begin
            r_exp = XLEN'(switches);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            due         = 1'b0;
            port_m      = '{default: '0};
            cnt_seen    = 1'b0;
            cnt_cleared = 1'b0;
        end else begin
            if (due && !ack) begin
                fail_cnt++;
                $display("error at %0t: no ack in the cycle after an accepted request", $time);
            end else if (due) begin
                ack_cnt++;
                if (!r_we && r_cycle) begin
                    check_counter(dat_r);
                end else if (!r_we) begin
                    check_value("dat_r", dat_r, r_exp);
                end else begin
                    check_value("leds", XLEN'(leds), port_m[0]);
                    check_value("car_fcw", XLEN'(car_fcw), port_m[1]);
                    check_value("mod_fcw", XLEN'(mod_fcw), port_m[2]);
                    check_value("mod_shift", XLEN'(mod_shift), port_m[3]);
                    check_value("note_en", XLEN'(note_en), port_m[4]);
                    check_value("tx_en", XLEN'(tx_en), port_m[5]);
                end
            end else if (ack) begin
                fail_cnt++;
                $display("error at %0t: ack without an accepted request", $time);
            end
            due = cyc && stb && !ack;
            if (due) take_request();
        end
    end

endmodule

/* tb_data_port.sv */
`timescale 1ns/1ps

module tb_data_port import lsu_pkg::*; ();

    typedef struct packed {
        logic             we;
        logic [2:0]       size;
        logic [XLEN-1:0]  adr;
        logic [XLEN-1:0]  dat_w;
        logic [BTN_W-1:0] btn;
        logic [SW_W-1:0]  sw;
    } access_t;

    logic               clk, rst, cyc, stb, we, ack;
    logic [2:0]         size;
    logic [XLEN-1:0]    adr, dat_w, dat_r;
    logic [BTN_W-1:0]   buttons;
    logic [SW_W-1:0]    switches;
    logic [LED_W-1:0]   leds;
    logic [FCW_W-1:0]   car_fcw, mod_fcw;
    logic [SHIFT_W-1:0] mod_shift;
    logic               note_en, tx_en;
    int                 mismatches, failures, acks;
    int                 limit = 0;      // Cycle budget, known once the table is built
    int                 cycles = 0;
    access_t            table_q[$];

    data_port_top DUT (.*);
    tb_checker u_checker (.*);

    bind data_port_top tb_data_port_assert u_assert (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .ack(ack), .note_en(note_en), .tx_en(tx_en)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic add_entry(input logic w, input logic [2:0] sz, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] d, input logic [BTN_W-1:0] b,
                             input logic [SW_W-1:0] s);
        table_q.push_back(access_t'{w, sz, a, d, b, s});
    endtask

    task automatic add_store(input logic [2:0] sz, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] d);
        add_entry(1'b1, sz, a, d, '0, '0);
    endtask

    task automatic add_load(input logic [2:0] sz, input logic [XLEN-1:0] a);
        add_entry(1'b0, sz, a, '0, '0, '0);
    endtask

    task automatic fill_table();
        logic [XLEN-1:0] base;
        // Partial stores merged into one RAM word
        add_store(F3_SW, 32'h1000_0000, 32'h1122_3344);
        add_load(F3_LW, 32'h1000_0000);
        add_store(F3_SB, 32'h1000_0001, $urandom);
        add_load(F3_LW, 32'h1000_0000);
        add_store(F3_SH, 32'h1000_0002, $urandom);
        add_load(F3_LW, 32'h1000_0000);
        add_store(F3_SH, 32'h1000_0003, 32'hdead_beef);    // Straddles, no write
        add_load(F3_LW, 32'h1000_0000);
        add_store(F3_SW, 32'h1000_0004, $urandom);
        add_store(F3_SB, 32'h1000_0007, $urandom);
        add_store(F3_SH, 32'h1000_0005, $urandom);
        add_load(F3_LW, 32'h1000_0004);
        add_store(F3_SW, 32'h1000_fffc, $urandom);          // Top word of the RAM
        add_load(F3_LW, 32'h1000_fffc);
        // Sub-word loads over a fixed and a random word
        add_store(F3_SW, 32'h1000_0008, 32'h80ff_7f01);
        add_store(F3_SW, 32'h1000_000c, $urandom);
        for (int w = 0; w < 2; w++) begin
            base = 32'h1000_0008 + 32'(4 * w);
            for (int off = 0; off < 4; off++) begin
                add_load(F3_LB, base + 32'(off));
                add_load(F3_LBU, base + 32'(off));
                if (off < 3) begin
                    add_load(F3_LH, base + 32'(off));
                    add_load(F3_LHU, base + 32'(off));
                end
            end
        end
        // Output registers
        add_store(F3_SW, ADDR_LEDS, $urandom);
        add_store(F3_SW, ADDR_CAR_FCW, $urandom);
        add_store(F3_SW, ADDR_MOD_FCW, $urandom);
        add_store(F3_SB, ADDR_MOD_SHIFT, $urandom);
        add_store(F3_SW, ADDR_NOTE_EN, 32'h0000_0001);
        add_store(F3_SW, ADDR_TX_EN, 32'hffff_ffff);
        add_store(F3_SW, 32'h8000_0020, $urandom);          // Unmapped, no port moves
        add_store(F3_SH, ADDR_NOTE_EN, 32'h0000_fffe);
        // Board inputs and unmapped reads
        add_entry(1'b0, F3_LW, ADDR_BUTTONS, '0, 3'b101, 2'b10);
        add_entry(1'b0, F3_LW, ADDR_SWITCHES, '0, 3'b010, 2'b01);
        add_entry(1'b0, F3_LW, ADDR_BUTTONS, '0, 3'b111, 2'b11);
        add_entry(1'b0, F3_LW, 32'h8000_0300, '0, 3'b111, 2'b11);
        add_load(F3_LW, 32'h2000_0000);
        // Cycle counter, a byte store must not clear it
        add_load(F3_LW, ADDR_CYCLE);
        add_load(F3_LW, ADDR_CYCLE);
        add_store(F3_SB, ADDR_CYCLE_CLR, 32'h0);
        add_load(F3_LW, ADDR_CYCLE);
        add_store(F3_SW, ADDR_CYCLE_CLR, 32'h0);
        add_load(F3_LW, ADDR_CYCLE);
    endtask

    // One bus access held through its ack cycle, then a cycle with stb low
    task automatic run_access(input access_t a);
        cyc      = 1'b1;
        stb      = 1'b1;
        we       = a.we;
        size     = a.size;
        adr      = a.adr;
        dat_w    = a.dat_w;
        buttons  = a.btn;
        switches = a.sw;
        do @(negedge clk); while (!ack);
        @(negedge clk);     // Request stays up over the ack edge and must not be taken twice
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'h74e63f88));
        rst      = 1'b1;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        size     = '0;
        adr      = '0;
        dat_w    = '0;
        buttons  = '0;
        switches = '0;
        fill_table();
        limit = 16 + 4 * table_q.size() + 50;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        foreach (table_q[i]) begin
            run_access(table_q[i]);
        end
        repeat (3) @(negedge clk);
        if (acks != table_q.size()) begin
            $display("error: %0d accesses sent but %0d acknowledged", table_q.size(), acks);
        end
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, DUT.u_assert.assert_fails);
        if (mismatches == 0 && failures == 0 && DUT.u_assert.assert_fails == 0
                && acks == table_q.size()) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        wait (limit != 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("error: run did not finish within %0d cycles", limit);
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures + 1, DUT.u_assert.assert_fails);
        $display("Regression failed");
        $finish;
    end

endmodule

/* tb_data_port_assert.sv */
`timescale 1ns/1ps

module tb_data_port_assert (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic note_en,
    input logic tx_en
);

    int assert_fails = 0;

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else begin
            assert_fails++;
            $error("ack high in two cycles in a row");
        end

    // ack only answers a request taken on the previous edge
    ack_after_accept: assert property (@(posedge clk) disable iff (rst)
                                       ack |-> $past(cyc && stb && !ack))
        else begin
            assert_fails++;
            $error("ack without an accepted request on the previous edge");
        end

    accept_gets_ack: assert property (@(posedge clk) disable iff (rst)
                                      cyc && stb && !ack |=> ack)
        else begin
            assert_fails++;
            $error("accepted request not followed by ack");
        end

    reset_state: assert property (@(posedge clk) $past(rst) && !rst |-> !ack && !note_en && !tx_en)
        else begin
            assert_fails++;
            $error("ack, note_en or tx_en high right after reset");
        end

endmodule

/* wb_access_ctrl.sv */
`timescale 1ns/1ps

module wb_access_ctrl import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            cyc,
    input  logic            stb,
    input  logic [XLEN-1:0] adr,
    input  logic [2:0]      size,
    output logic            accept,
    output logic            ram_sel,
    output logic            io_sel,
    input  logic [XLEN-1:0] ram_word,
    input  logic [XLEN-1:0] io_word,
    output logic [XLEN-1:0] dat_r,
    output logic            ack
);

    logic [2:0]      size_q;
    logic [1:0]      offset_q;
    logic            ram_q;     // Access in flight hit the RAM
    logic            io_q;      // Access in flight hit the I/O space
    logic [XLEN-1:0] ram_ext;

    // A request held through ack is not taken twice
    assign accept = cyc & stb & ~ack;

    // Data RAM sits at 0x1xxx_xxxx with bits 31:30 clear
    assign ram_sel = (adr[31:30] == 2'b00) && adr[28];
    assign io_sel  = (adr[31:28] == 4'b1000);

    always_ff @(posedge clk) begin
        if (rst) begin
            ack  <= 1'b0;
            ram_q <= 1'b0;
            io_q  <= 1'b0;
        end else begin
            ack <= accept;
            if (accept) begin
                ram_q <= ram_sel;
                io_q  <= io_sel;
            end
        end
    end

    // Load attributes for the extend step
    always_ff @(posedge clk) begin
        if (accept) begin
            size_q   <= size;
            offset_q <= adr[1:0];
        end
    end

    load_extend u_extend (
        .size   (size_q),
        .offset (offset_q),
        .word   (ram_word),
        .value  (ram_ext)
    );

    always_comb begin
        if (ram_q) begin
            dat_r = ram_ext;
        end else if (io_q) begin
            dat_r = io_word;    // Already zero for unmapped I/O reads
        end else begin
            dat_r = '0;
        end
    end

endmodule
